// ==== list.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_axi_master.sv
rtl/lsu_load_align.sv
rtl/axi_sram_slave.sv
rtl/lsu_top.sv
bench/lsu_assert.sv
bench/lsu_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the lsu testbench, pass only if the simulation prints the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module lsu_tb -o lsu_sim &&
./obj_dir/lsu_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== bench/lsu_tb.sv ====
`include "lsu_defines.svh"

module lsu_tb import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int FINISH_LIMIT = 50;
    localparam int N_RANDOM     = 200;
    localparam int N_OPS        = 67 + N_RANDOM;  // directed ops plus random ops

    logic     clk;
    logic     rst;
    logic     load_req;
    load_op_t load_op;
    addr_t    load_addr;
    word_t    rd_data;
    logic     rd_finish;
    logic     store_req;
    addr_t    store_addr;
    word_t    store_data;
    strb_t    store_strb;
    logic     wr_finish;

    word_t ref_mem [`LSU_MEM_WORDS];
    word_t exp_q [$];   // expected rd_data, oldest first
    word_t exp_val;
    int    seed = 78995;
    int    err_val;
    int    err_other;
    int    n_checks;
    int    n_loads;
    int    n_stores;
    int    rd_seen;
    int    wr_seen;

    lsu_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .load_req   (load_req),
        .load_op    (load_op),
        .load_addr  (load_addr),
        .rd_data    (rd_data),
        .rd_finish  (rd_finish),
        .store_req  (store_req),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_strb (store_strb),
        .wr_finish  (wr_finish)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic void apply_store(addr_t addr, word_t data, strb_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) ref_mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
        end
    endfunction

    function automatic word_t expected_load(addr_t addr, load_op_t op);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[addr[9:2]];
        case (addr[1:0])
            2'd0: b = w[7:0];
            2'd1: b = w[15:8];
            2'd2: b = w[23:16];
            default: b = w[31:24];
        endcase
        h = addr[1] ? w[31:16] : w[15:0];  // halfwords sit at offset 0 or 2
        case (op)
            LD_LB:   return {{24{b[7]}}, b};
            LD_LBU:  return {24'h0, b};
            LD_LH:   return {{16{h[15]}}, h};
            LD_LHU:  return {16'h0, h};
            LD_LW:   return w;
            default: return '0;
        endcase
    endfunction

    function automatic load_op_t pick_load_op(word_t r);
        case (r[15:8] % 8'd5)
            8'd0:    return LD_LB;
            8'd1:    return LD_LBU;
            8'd2:    return LD_LH;
            8'd3:    return LD_LHU;
            default: return LD_LW;
        endcase
    endfunction

    // natural alignment for the access size
    function automatic addr_t load_address(load_op_t op, addr_t a);
        if (op == LD_LW) return {a[31:2], 2'b00};
        if (op == LD_LH || op == LD_LHU) return {a[31:1], 1'b0};
        return a;
    endfunction

    task automatic issue_store(input addr_t addr, input word_t data, input strb_t strb);
        int waited;
        @(posedge clk);
        #2;
        store_req  = 1'b1;
        store_addr = addr;
        store_data = data;
        store_strb = strb;
        apply_store(addr, data, strb);
        n_stores++;
        @(posedge clk);
        #2;
        store_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!wr_finish && waited < FINISH_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (wr_finish) else begin
            $display("missing wr_finish: store to %08h not answered in %0d cycles",
                     addr, FINISH_LIMIT);
            err_other++;
        end
    endtask

    task automatic issue_load(input load_op_t op, input addr_t addr);
        int waited;
        @(posedge clk);
        #2;
        load_req  = 1'b1;
        load_op   = op;
        load_addr = addr;
        exp_q.push_back(expected_load(addr, op));
        n_loads++;
        @(posedge clk);
        #2;
        load_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rd_finish && waited < FINISH_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (rd_finish) else begin
            $display("missing rd_finish: load from %08h not answered in %0d cycles",
                     addr, FINISH_LIMIT);
            err_other++;
            exp_q.delete();  // drop the stale expectation
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!rd_finish) else begin
                $display("ERR t=%0t rd_finish expected 0 got %0b", $time, rd_finish);
                err_val++;
            end
            assert (!wr_finish) else begin
                $display("ERR t=%0t wr_finish expected 0 got %0b", $time, wr_finish);
                err_val++;
            end
            assert (rd_data == '0) else begin
                $display("ERR t=%0t rd_data expected %08h got %08h", $time, 32'h0, rd_data);
                err_val++;
            end
        end
    endtask

    // rd_data is valid in the rd_finish cycle itself
    always @(negedge clk) begin
        if (!rst && rd_finish) begin
            rd_seen++;
            if (exp_q.size() == 0) begin
                $display("rd_finish at %0t with no load pending", $time);
                err_other++;
            end else begin
                exp_val = exp_q.pop_front();
                n_checks++;
                assert (rd_data == exp_val) else begin
                    $display("ERR t=%0t rd_data expected %08h got %08h",
                             $time, exp_val, rd_data);
                    err_val++;
                end
            end
        end
        if (!rst && wr_finish) wr_seen++;
    end

    initial begin
        repeat (N_OPS * 40 + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete",
                 N_OPS * 40 + RESET_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        word_t    r_ctl;
        word_t    r_addr;
        word_t    r_data;
        addr_t    addr;
        load_op_t op;
        rst        = 1'b1;
        load_req   = 1'b0;
        load_op    = LD_NONE;
        load_addr  = '0;
        store_req  = 1'b0;
        store_addr = '0;
        store_data = '0;
        store_strb = '0;
        for (int i = 0; i < `LSU_MEM_WORDS; i++) ref_mem[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        check_idle(10);

        // full words, first and last word included
        issue_store(32'h0000_0000, 32'hdead_beef, 4'hf);
        issue_load(LD_LW, 32'h0000_0000);
        issue_store(32'h0000_03fc, 32'h1234_5678, 4'hf);
        issue_load(LD_LW, 32'h0000_03fc);
        issue_store(32'h0000_0124, 32'hffff_ffff, 4'hf);
        issue_load(LD_LW, 32'h0000_0124);

        // every nonzero strobe pattern on one word
        issue_store(32'h0000_0100, 32'h0123_4567, 4'hf);
        for (int s = 1; s < 16; s++) begin
            r_data = $random(seed);
            issue_store(32'h0000_0100, r_data, 4'(s));
            issue_load(LD_LW, 32'h0000_0100);
        end

        // bytes alternate top bit set and clear across the two words
        issue_store(32'h0000_0200, 32'h7f80_01fe, 4'hf);
        issue_store(32'h0000_0204, 32'h807f_fe01, 4'hf);
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                issue_load(LD_LB, 32'h0000_0200 + 32'(4 * w + off));
                issue_load(LD_LBU, 32'h0000_0200 + 32'(4 * w + off));
            end
        end

        issue_store(32'h0000_0300, 32'h8001_7ffe, 4'hf);
        issue_store(32'h0000_0304, 32'h7fff_8000, 4'hf);
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off += 2) begin
                issue_load(LD_LH, 32'h0000_0300 + 32'(4 * w + off));
                issue_load(LD_LHU, 32'h0000_0300 + 32'(4 * w + off));
            end
        end
        issue_load(LD_NONE, 32'h0000_0300);
        issue_load(LD_NONE, 32'h0000_0304);

        // random mix over 16 words, upper address bits random
        for (int i = 0; i < N_RANDOM; i++) begin
            r_ctl  = $random(seed);
            r_addr = $random(seed);
            r_data = $random(seed);
            addr   = {r_addr[31:10], 4'b0000, r_addr[5:0]};
            if (r_ctl[0]) begin
                issue_store({addr[31:2], 2'b00}, r_data, r_ctl[7:4]);
            end else begin
                op = pick_load_op(r_ctl);
                issue_load(op, load_address(op, addr));
            end
        end

        repeat (3) @(posedge clk);
        assert (wr_seen == n_stores) else begin
            $display("%0d stores issued but %0d wr_finish pulses seen", n_stores, wr_seen);
            err_other++;
        end
        assert (rd_seen == n_loads) else begin
            $display("%0d loads issued but %0d rd_finish pulses seen", n_loads, rd_seen);
            err_other++;
        end
        assert (i_dut.u_master.i_assert.fail_cnt == 0) else begin
            $display("protocol assertions failed %0d times", i_dut.u_master.i_assert.fail_cnt);
            err_other++;
        end
        $display("errors: %0d wrong value, %0d other (%0d rd_data checks, %0d stores)",
                 err_val, err_other, n_checks, n_stores);
        if (err_val == 0 && err_other == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/lsu_assert.sv ====
module lsu_assert (
    input logic clk,
    input logic rst,
    input logic arvalid,
    input logic arready,
    input logic rvalid,
    input logic rready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic rd_finish,
    input logic wr_finish
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fail_cnt;
    logic ar_seen;  // address accepted, read data not yet taken

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_seen <= 1'b0;
        end else if (arvalid && arready) begin
            ar_seen <= 1'b1;
        end else if (rvalid && rready) begin
            ar_seen <= 1'b0;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before its handshake");
            fail_cnt++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before its handshake");
            fail_cnt++;
        end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before its handshake");
            fail_cnt++;
        end

    a_rd_pulse: assert property (@(posedge clk) disable iff (rst)
        rd_finish |=> !rd_finish)
        else begin
            $error("rd_finish high for two cycles");
            fail_cnt++;
        end

    a_wr_pulse: assert property (@(posedge clk) disable iff (rst)
        wr_finish |=> !wr_finish)
        else begin
            $error("wr_finish high for two cycles");
            fail_cnt++;
        end

    a_rready_after_ar: assert property (@(posedge clk) disable iff (rst)
        rready |-> ar_seen)
        else begin
            $error("rready raised without a read address handshake");
            fail_cnt++;
        end

endmodule

bind lsu_axi_master lsu_assert i_assert (
    .clk       (clk),
    .rst       (rst),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rready    (rready),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .rd_finish (rd_finish),
    .wr_finish (wr_finish)
);

// ==== rtl/lsu_top.sv ====
module lsu_top import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_req,
    input  load_op_t load_op,
    input  addr_t    load_addr,
    output word_t    rd_data,
    output logic     rd_finish,
    input  logic     store_req,
    input  addr_t    store_addr,
    input  word_t    store_data,
    input  strb_t    store_strb,
    output logic     wr_finish
);

    // axi-lite between master and sram
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rvalid;
    logic       rready;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;

    // latched load result into the align stage
    word_t      ld_word;
    logic [1:0] ld_offset;
    load_op_t   ld_kind;

    lsu_axi_master u_master (
        .clk        (clk),
        .rst        (rst),
        .load_req   (load_req),
        .load_op    (load_op),
        .load_addr  (load_addr),
        .store_req  (store_req),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_strb (store_strb),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .ld_word    (ld_word),
        .ld_offset  (ld_offset),
        .ld_kind    (ld_kind),
        .rd_finish  (rd_finish),
        .wr_finish  (wr_finish)
    );

    lsu_load_align u_align (
        .ld_word   (ld_word),
        .ld_offset (ld_offset),
        .ld_kind   (ld_kind),
        .rd_data   (rd_data)
    );

    axi_sram_slave u_sram (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// ==== rtl/axi_sram_slave.sv ====
`include "lsu_defines.svh"

module axi_sram_slave import lsu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata,
    output logic  rvalid,
    input  logic  rready,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  word_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    output logic  bvalid,
    input  logic  bready
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int LANES = `LSU_XLEN / 8;

    typedef enum logic {
        SR_IDLE,
        SR_VALID
    } sram_rd_t;

    sram_rd_t         rd_state;
    word_t            mem [`LSU_MEM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_go;
    logic             bvalid_q;

    // word index, byte offset bits dropped
    assign rd_idx = araddr[IDX_W+1:2];
    assign wr_idx = awaddr[IDX_W+1:2];

    assign arready = (rd_state == SR_IDLE);
    assign rvalid  = (rd_state == SR_VALID);

    // address and data accepted together, and only once the last response is gone
    assign wr_go   = awvalid && wvalid && !bvalid_q;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign bvalid  = bvalid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= SR_IDLE;
        end else begin
            case (rd_state)
                SR_IDLE: begin
                    if (arvalid) rd_state <= SR_VALID;   // arready is high here
                end
                SR_VALID: begin
                    if (rready) rd_state <= SR_IDLE;
                end
                default: rd_state <= SR_IDLE;
            endcase
        end
    end

    // rdata held until the read data transfer
    always_ff @(posedge clk) begin
        if (arvalid && arready) rdata <= mem[rd_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_go) begin
            for (int b = 0; b < LANES; b++) begin
                if (wstrb[b]) mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (wr_go) begin
            bvalid_q <= 1'b1;
        end else if (bvalid_q && bready) begin
            bvalid_q <= 1'b0;
        end
    end

endmodule

// ==== rtl/lsu_load_align.sv ====
`include "lsu_defines.svh"

module lsu_load_align import lsu_pkg::*; (
    input  word_t      ld_word,
    input  logic [1:0] ld_offset,
    input  load_op_t   ld_kind,
    output word_t      rd_data
);

    word_t shifted;

    // addressed byte moves down to lane 0
    assign shifted = ld_word >> {ld_offset, 3'b000};

    always_comb begin
        case (ld_kind)
            LD_LB: begin
                rd_data = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            LD_LBU: begin
                rd_data = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            end
            LD_LH: begin
                rd_data = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            LD_LHU: begin
                rd_data = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            end
            LD_LW: begin
                rd_data = shifted;   // offset 0 expected for words
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

// ==== rtl/lsu_axi_master.sv ====
`include "lsu_defines.svh"

module lsu_axi_master import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_req,
    input  load_op_t   load_op,
    input  addr_t      load_addr,
    input  logic       store_req,
    input  addr_t      store_addr,
    input  word_t      store_data,
    input  strb_t      store_strb,
    output addr_t      araddr,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rvalid,
    output logic       rready,
    output addr_t      awaddr,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    output logic       bready,
    output word_t      ld_word,
    output logic [1:0] ld_offset,
    output load_op_t   ld_kind,
    output logic       rd_finish,
    output logic       wr_finish
);

    localparam int CNT_W = $clog2(`LSU_R_DELAY > `LSU_AR_DELAY ? `LSU_R_DELAY : `LSU_AR_DELAY) + 1;

    rd_state_t        rd_state;
    logic [CNT_W-1:0] rd_cnt;
    addr_t            rd_addr_q;
    load_op_t         req_kind;   // kind of the load in flight
    word_t            word_q;
    logic [1:0]       offset_q;
    load_op_t         kind_q;     // kind of the last completed load
    logic             ar_hs;
    logic             r_hs;

    wr_state_t        wr_state;
    addr_t            wr_addr_q;
    word_t            wr_data_q;
    strb_t            wr_strb_q;
    logic             awvalid_q;
    logic             wvalid_q;
    logic             aw_hs;
    logic             w_hs;
    logic             b_hs;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    assign araddr    = rd_addr_q;
    assign arvalid   = (rd_state == RD_ADDR);
    assign rready    = (rd_state == RD_DATA);
    assign rd_finish = r_hs;

    // bypass so rd_data is already valid in the handshake cycle
    assign ld_word   = r_hs ? rdata : word_q;
    assign ld_offset = r_hs ? rd_addr_q[1:0] : offset_q;
    assign ld_kind   = r_hs ? req_kind : kind_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
            kind_q   <= LD_NONE;   // keeps rd_data at zero until first load
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (load_req) begin
                        rd_cnt   <= CNT_W'(`LSU_AR_DELAY - 2);
                        rd_state <= RD_WAIT_AR;
                    end
                end
                RD_WAIT_AR: begin
                    if (rd_cnt == '0) rd_state <= RD_ADDR;
                    else rd_cnt <= rd_cnt - 1'b1;
                end
                RD_ADDR: begin
                    if (ar_hs) begin
                        rd_cnt   <= CNT_W'(`LSU_R_DELAY - 2);
                        rd_state <= RD_WAIT_R;
                    end
                end
                RD_WAIT_R: begin
                    if (rd_cnt == '0) rd_state <= RD_DATA;
                    else rd_cnt <= rd_cnt - 1'b1;
                end
                RD_DATA: begin
                    if (r_hs) begin
                        kind_q   <= req_kind;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state == RD_IDLE && load_req) begin
            rd_addr_q <= load_addr;
            req_kind  <= load_op;
        end
        if (r_hs) begin
            word_q   <= rdata;
            offset_q <= rd_addr_q[1:0];
        end
    end

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    assign awaddr    = wr_addr_q;
    assign wdata     = wr_data_q;
    assign wstrb     = wr_strb_q;
    assign awvalid   = awvalid_q;
    assign wvalid    = wvalid_q;
    assign bready    = !rst;   // response always accepted
    assign wr_finish = (wr_state == WR_RESP) && b_hs;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state  <= WR_IDLE;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (store_req) begin
                        awvalid_q <= 1'b1;
                        wvalid_q  <= 1'b1;
                        wr_state  <= WR_REQ;
                    end
                end
                WR_REQ: begin
                    // each channel drops its valid on its own handshake
                    if (aw_hs) awvalid_q <= 1'b0;
                    if (w_hs) wvalid_q <= 1'b0;
                    if ((aw_hs || !awvalid_q) && (w_hs || !wvalid_q)) wr_state <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_hs) wr_state <= WR_IDLE;
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_state == WR_IDLE && store_req) begin
            wr_addr_q <= store_addr;
            wr_data_q <= store_data;  // already lane aligned by the issuer
            wr_strb_q <= store_strb;
        end
    end

endmodule

// ==== rtl/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   addr_t;  // byte address
    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [`LSU_XLEN/8-1:0] strb_t;  // one bit per byte lane

    // encodings follow the core's memory read control
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_LB   = 3'd1,
        LD_LBU  = 3'd2,
        LD_LH   = 3'd3,
        LD_LHU  = 3'd4,
        LD_LW   = 3'd5
    } load_op_t;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_WAIT_AR,  // counting down to arvalid
        RD_ADDR,
        RD_WAIT_R,   // counting down to rready
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_REQ,
        WR_RESP
    } wr_state_t;

endpackage

// ==== rtl/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and address width
`define LSU_XLEN 32

// sram depth in words, indexed by address bits 9:2
`define LSU_MEM_WORDS 256

// cycles from load strobe to arvalid (at least 2)
`define LSU_AR_DELAY 3

// cycles from read address handshake to rready (at least 2)
`define LSU_R_DELAY 7

`endif
